/* canny_stimulus.mem */
// pixel (2 hex digits), expected edge bit (1 digit), expected rgb (6 digits)
// One line per pixel in raster order, 8 x 6 frame with a 0x40 block at rows 2-3, columns 3-5
000FF0000
000FF0000
000FF0000
000FF0000
000FF0000
000FF0000
000FF0000
000FF0000
000FF0000
000FF0000
000FF00FF
000FF00FF
0000000FF
0000000FF
00000FFFF
000FF0000
000FF0000
000FF0000
0008000FF
401FF00FF
4000000FF
40100FFFF
00000FFFF
000FF0000
000FF0000
000FF0000
000FF0000
401FF0000
400FF8000
401FFFF00
00000FF00
000FF0000
000FF0000
000FF0000
000FF0000
000FF8000
000FF8000
000FFFF00
000FFFF00
000FF0000
000FF0000
000FF0000
000FF0000
000FF0000
000FF0000
000FF0000
000FF0000
000FF0000

/* files.f */
canny_pkg.sv
img_bus_if.sv
axi4s_img_adapter.sv
img_window3x3.sv
img_sobel.sv
img_nms.sv
angle_colormap.sv
canny_top.sv
tb_canny_top.sv

/* tb_canny_top.sv */
`timescale 1ns/1ps

module tb_canny_top
    import canny_pkg::*;
();

    localparam int NPIX          = IMG_X * IMG_Y;
    localparam int FLUSH_CYCLES  = FLUSH_LINES * IMG_X;
    localparam int READY_TIMEOUT = 500;
    localparam int BEAT_TIMEOUT  = 4000;

    logic        aclk;
    logic        rst_n_i;
    pixel_t      s_axis_src_tdata_i;
    logic        s_axis_src_tuser_i;
    logic        s_axis_src_tlast_i;
    logic        s_axis_src_tvalid_i;
    logic        s_axis_src_tready_o;
    pixel_t      m_axis_dst_tdata_o;
    logic        m_axis_dst_tuser_o;
    logic        m_axis_dst_tlast_o;
    logic        m_axis_dst_tvalid_o;
    logic        m_axis_dst_tready_i;
    rgb_t        m_axis_angle_tdata_o;
    logic        m_axis_angle_tuser_o;
    logic        m_axis_angle_tlast_o;
    logic        m_axis_angle_tvalid_o;

    logic [35:0] stim_mem [NPIX];
    logic [9:0]  dst_q [$];
    logic [25:0] ang_q [$];
    logic        held_valid;
    logic [9:0]  held_beat;
    int          bp_pct;
    int          flush_done;
    int          src_beats;
    int          low_cycles;
    int          seed_val;
    int unsigned rnd_init;

    canny_top i_canny_top (
        .aclk                  (aclk),
        .rst_n_i               (rst_n_i),
        .s_axis_src_tdata_i    (s_axis_src_tdata_i),
        .s_axis_src_tuser_i    (s_axis_src_tuser_i),
        .s_axis_src_tlast_i    (s_axis_src_tlast_i),
        .s_axis_src_tvalid_i   (s_axis_src_tvalid_i),
        .s_axis_src_tready_o   (s_axis_src_tready_o),
        .m_axis_dst_tdata_o    (m_axis_dst_tdata_o),
        .m_axis_dst_tuser_o    (m_axis_dst_tuser_o),
        .m_axis_dst_tlast_o    (m_axis_dst_tlast_o),
        .m_axis_dst_tvalid_o   (m_axis_dst_tvalid_o),
        .m_axis_dst_tready_i   (m_axis_dst_tready_i),
        .m_axis_angle_tdata_o  (m_axis_angle_tdata_o),
        .m_axis_angle_tuser_o  (m_axis_angle_tuser_o),
        .m_axis_angle_tlast_o  (m_axis_angle_tlast_o),
        .m_axis_angle_tvalid_o (m_axis_angle_tvalid_o)
    );

    always #4 aclk = ~aclk;

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        abort_run();
    endtask

    task automatic expect_hex(input string sig, input int index, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s at index %0d: got 0x%0h, expected 0x%0h", sig, index, got, exp);
            abort_run();
        end
    endtask

    // ********************************************************************
    // Source driver
    // ********************************************************************

    task automatic push_pixel(input int idx);
        int waited;
        s_axis_src_tdata_i  = stim_mem[idx][35:28];
        s_axis_src_tuser_i  = (idx == 0);
        s_axis_src_tlast_i  = ((idx % IMG_X) == IMG_X - 1);
        s_axis_src_tvalid_i = 1'b1;
        waited = 0;
        @(negedge aclk);
        while (s_axis_src_tready_o !== 1'b1) begin
            waited++;
            if (waited > READY_TIMEOUT) begin
                report_problem("Timed out waiting for the source stream to accept a pixel");
            end
            @(negedge aclk);
        end
        @(posedge aclk);
        #1;
        s_axis_src_tvalid_i = 1'b0;
        s_axis_src_tuser_i  = 1'b0;
        s_axis_src_tlast_i  = 1'b0;
    endtask

    task automatic send_frame(input int with_gaps);
        int idx;
        int gap;
        @(posedge aclk);
        #1;
        for (idx = 0; idx < NPIX; idx++) begin
            gap = 0;
            if (with_gaps != 0 && idx != 0 && $urandom_range(0, 1) == 1) begin
                gap = $urandom_range(1, 3);
            end
            repeat (gap) begin
                @(posedge aclk);
                #1;
            end
            push_pixel(idx);
        end
    endtask

    // Random stall on the destination drawn once per cycle
    always @(posedge aclk) begin
        #1;
        if (bp_pct > 0 && $urandom_range(0, 99) < bp_pct) begin
            m_axis_dst_tready_i = 1'b0;
        end else begin
            m_axis_dst_tready_i = 1'b1;
        end
    end

    // ********************************************************************
    // Monitors
    // ********************************************************************

    always @(negedge aclk) begin
        if (held_valid) begin
            expect_hex("m_axis_dst_tvalid_o held", dst_q.size(), m_axis_dst_tvalid_o, 1'b1);
            expect_hex("m_axis_dst_tdata_o held", dst_q.size(), m_axis_dst_tdata_o,
                       held_beat[7:0]);
            expect_hex("m_axis_dst_tuser_o held", dst_q.size(), m_axis_dst_tuser_o, held_beat[9]);
            expect_hex("m_axis_dst_tlast_o held", dst_q.size(), m_axis_dst_tlast_o, held_beat[8]);
        end
        if (m_axis_dst_tvalid_o === 1'b1 && m_axis_dst_tready_i === 1'b1) begin
            dst_q.push_back({m_axis_dst_tuser_o, m_axis_dst_tlast_o, m_axis_dst_tdata_o});
        end
        held_valid = (m_axis_dst_tvalid_o === 1'b1) && (m_axis_dst_tready_i === 1'b0);
        held_beat  = {m_axis_dst_tuser_o, m_axis_dst_tlast_o, m_axis_dst_tdata_o};
    end

    always @(negedge aclk) begin
        if (m_axis_angle_tvalid_o === 1'b1) begin
            ang_q.push_back({m_axis_angle_tuser_o, m_axis_angle_tlast_o, m_axis_angle_tdata_o});
        end
    end

    // Source must stay blocked for the blank lines after each frame
    initial begin
        forever begin
            @(negedge aclk);
            if (rst_n_i && s_axis_src_tvalid_i && s_axis_src_tready_o) begin
                src_beats++;
                if (src_beats % NPIX == 0) begin
                    low_cycles = 0;
                    @(negedge aclk);
                    while (s_axis_src_tready_o !== 1'b1) begin
                        low_cycles++;
                        if (low_cycles > READY_TIMEOUT) begin
                            report_problem("Source tready never returned high after a frame");
                        end
                        @(negedge aclk);
                    end
                    assert (low_cycles >= FLUSH_CYCLES) else begin
                        $display("[FAIL] %s after frame %0d: got 0x%0h, expected at least 0x%0h",
                                 "s_axis_src_tready_o low cycles", src_beats / NPIX, low_cycles,
                                 FLUSH_CYCLES);
                        abort_run();
                    end
                    flush_done++;
                    // A following frame can start in the cycle tready returns
                    if (s_axis_src_tvalid_i === 1'b1) begin
                        src_beats++;
                    end
                end
            end
        end
    end

    // ********************************************************************
    // Checker
    // ********************************************************************

    task automatic check_frames(input int nframes);
        int         total;
        int         waited;
        int         i;
        int         idx;
        logic [9:0] dbeat;
        logic [25:0] abeat;
        total  = nframes * NPIX;
        waited = 0;
        while (dst_q.size() < total || ang_q.size() < total) begin
            waited++;
            if (waited > BEAT_TIMEOUT) begin
                report_problem("Timed out waiting for the output beats of a frame");
            end
            @(negedge aclk);
        end
        for (i = 0; i < total; i++) begin
            idx   = i % NPIX;
            dbeat = dst_q.pop_front();
            abeat = ang_q.pop_front();
            expect_hex("m_axis_dst_tdata_o", i, dbeat[7:0], stim_mem[idx][24] ? 8'hFF : 8'h00);
            expect_hex("m_axis_dst_tuser_o", i, dbeat[9], idx == 0);
            expect_hex("m_axis_dst_tlast_o", i, dbeat[8], (idx % IMG_X) == IMG_X - 1);
            expect_hex("m_axis_angle_tdata_o", i, abeat[23:0], stim_mem[idx][23:0]);
            expect_hex("m_axis_angle_tuser_o", i, abeat[25], idx == 0);
            expect_hex("m_axis_angle_tlast_o", i, abeat[24], (idx % IMG_X) == IMG_X - 1);
        end
    endtask

    task automatic wait_flush_checks(input int count);
        int waited;
        waited = 0;
        while (flush_done < count) begin
            waited++;
            if (waited > BEAT_TIMEOUT) begin
                report_problem("Timed out waiting for the blank lines after the last frame");
            end
            @(negedge aclk);
        end
    endtask

    initial begin
        aclk                = 1'b0;
        rst_n_i             = 1'b0;
        s_axis_src_tdata_i  = '0;
        s_axis_src_tuser_i  = 1'b0;
        s_axis_src_tlast_i  = 1'b0;
        s_axis_src_tvalid_i = 1'b0;
        m_axis_dst_tready_i = 1'b1;
        held_valid          = 1'b0;
        held_beat           = '0;
        bp_pct              = 0;
        flush_done          = 0;
        src_beats           = 0;
        low_cycles          = 0;
        seed_val            = 80;
        rnd_init            = $urandom(seed_val);
        $readmemh("canny_stimulus.mem", stim_mem);
        assert (!$isunknown(stim_mem[NPIX-1])) else begin
            report_problem("The stimulus file canny_stimulus.mem could not be read");
        end

        repeat (4) @(posedge aclk);
        #1;
        rst_n_i = 1'b1;
        @(negedge aclk);
        expect_hex("m_axis_dst_tvalid_o", 0, m_axis_dst_tvalid_o, 1'b0);
        expect_hex("m_axis_angle_tvalid_o", 0, m_axis_angle_tvalid_o, 1'b0);
        expect_hex("s_axis_src_tready_o", 0, s_axis_src_tready_o, 1'b1);

        // Edge map, colors and framing with a free-running sink
        send_frame(0);
        check_frames(1);

        // Random destination stalls
        bp_pct = 50;
        send_frame(0);
        check_frames(1);

        // Source gaps and two frames back to back
        bp_pct = 0;
        send_frame(1);
        send_frame(1);
        check_frames(2);
        wait_flush_checks(4);

        repeat (FLUSH_CYCLES) @(negedge aclk);
        assert (dst_q.size() == 0 && ang_q.size() == 0) else begin
            report_problem("An output stream produced more beats than the frames hold");
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* canny_top.sv */
`timescale 1ns/1ps

module canny_top
    import canny_pkg::*;
(
    input  logic   aclk,
    input  logic   rst_n_i,

    input  pixel_t s_axis_src_tdata_i,
    input  logic   s_axis_src_tuser_i,
    input  logic   s_axis_src_tlast_i,
    input  logic   s_axis_src_tvalid_i,
    output logic   s_axis_src_tready_o,

    output pixel_t m_axis_dst_tdata_o,
    output logic   m_axis_dst_tuser_o,
    output logic   m_axis_dst_tlast_o,
    output logic   m_axis_dst_tvalid_o,
    input  logic   m_axis_dst_tready_i,

    output rgb_t   m_axis_angle_tdata_o,
    output logic   m_axis_angle_tuser_o,
    output logic   m_axis_angle_tlast_o,
    output logic   m_axis_angle_tvalid_o
);

    logic            cke;
    pixel_t          pix_win [9];
    logic            pix_border;
    logic [MO_W-1:0] grad_win [9];
    angle_t          nms_angle;
    logic            ang_lf_q;
    logic            ang_pf_q;
    logic            ang_pl_q;
    logic            ang_de_q;
    logic            ang_valid_q;

    img_bus_if #(.DATA_W(PIX_W)) src_bus ();
    img_bus_if #(.DATA_W(PIX_W)) pix_bus ();
    img_bus_if #(.DATA_W(MO_W))  grad_bus ();
    img_bus_if #(.DATA_W(MO_W))  gwin_bus ();
    img_bus_if #(.DATA_W(1))     edge_bus ();

    axi4s_img_adapter i_adapter (
        .aclk                (aclk),
        .rst_n_i             (rst_n_i),
        .s_axis_src_tdata_i  (s_axis_src_tdata_i),
        .s_axis_src_tuser_i  (s_axis_src_tuser_i),
        .s_axis_src_tlast_i  (s_axis_src_tlast_i),
        .s_axis_src_tvalid_i (s_axis_src_tvalid_i),
        .s_axis_src_tready_o (s_axis_src_tready_o),
        .m_axis_dst_tdata_o  (m_axis_dst_tdata_o),
        .m_axis_dst_tuser_o  (m_axis_dst_tuser_o),
        .m_axis_dst_tlast_o  (m_axis_dst_tlast_o),
        .m_axis_dst_tvalid_o (m_axis_dst_tvalid_o),
        .m_axis_dst_tready_i (m_axis_dst_tready_i),
        .cke_o               (cke),
        .img_src             (src_bus.src),
        .img_snk             (edge_bus.snk)
    );

    img_window3x3 #(.DATA_W(PIX_W)) i_pix_window (
        .aclk     (aclk),
        .rst_n_i  (rst_n_i),
        .cke_i    (cke),
        .s        (src_bus.snk),
        .m        (pix_bus.src),
        .win_o    (pix_win),
        .border_o (pix_border)
    );

    img_sobel i_sobel (
        .aclk     (aclk),
        .rst_n_i  (rst_n_i),
        .cke_i    (cke),
        .win_i    (pix_win),
        .border_i (pix_border),
        .s        (pix_bus.snk),
        .m        (grad_bus.src)
    );

    img_window3x3 #(.DATA_W(MO_W)) i_grad_window (
        .aclk     (aclk),
        .rst_n_i  (rst_n_i),
        .cke_i    (cke),
        .s        (grad_bus.snk),
        .m        (gwin_bus.src),
        .win_o    (grad_win),
        .border_o ()
    );

    img_nms i_nms (
        .aclk    (aclk),
        .rst_n_i (rst_n_i),
        .cke_i   (cke),
        .win_i   (grad_win),
        .s       (gwin_bus.snk),
        .m       (edge_bus.src),
        .angle_o (nms_angle)
    );

    angle_colormap i_colormap (
        .aclk    (aclk),
        .rst_n_i (rst_n_i),
        .cke_i   (cke),
        .angle_i (nms_angle),
        .rgb_o   (m_axis_angle_tdata_o)
    );

    // ********************************************************************
    // Angle stream, flags held back one stage to meet the colormap
    // ********************************************************************

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ang_lf_q    <= 1'b0;
            ang_pf_q    <= 1'b0;
            ang_pl_q    <= 1'b0;
            ang_de_q    <= 1'b0;
            ang_valid_q <= 1'b0;
        end else if (cke) begin
            ang_lf_q    <= edge_bus.line_first;
            ang_pf_q    <= edge_bus.pixel_first;
            ang_pl_q    <= edge_bus.pixel_last;
            ang_de_q    <= edge_bus.de;
            ang_valid_q <= edge_bus.valid;
        end
    end

    assign m_axis_angle_tuser_o  = ang_lf_q & ang_pf_q;
    assign m_axis_angle_tlast_o  = ang_pl_q;
    assign m_axis_angle_tvalid_o = cke & ang_de_q & ang_valid_q;

endmodule

/* angle_colormap.sv */
`timescale 1ns/1ps

module angle_colormap
    import canny_pkg::*;
(
    input  logic   aclk,
    input  logic   rst_n_i,
    input  logic   cke_i,
    input  angle_t angle_i,
    output rgb_t   rgb_o
);

    // Eight hue steps, red through violet
    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rgb_o <= '0;
        end else if (cke_i) begin
            case (angle_i[7:5])
                3'd0:    rgb_o <= 24'hFF0000;
                3'd1:    rgb_o <= 24'hFF8000;
                3'd2:    rgb_o <= 24'hFFFF00;
                3'd3:    rgb_o <= 24'h00FF00;
                3'd4:    rgb_o <= 24'h00FFFF;
                3'd5:    rgb_o <= 24'h0000FF;
                3'd6:    rgb_o <= 24'hFF00FF;
                default: rgb_o <= 24'h8000FF;
            endcase
        end
    end

endmodule

/* img_nms.sv */
`timescale 1ns/1ps

module img_nms
    import canny_pkg::*;
(
    input  logic            aclk,
    input  logic            rst_n_i,
    input  logic            cke_i,
    input  logic [MO_W-1:0] win_i [9],
    img_bus_if.snk          s,
    img_bus_if.src          m,
    output angle_t          angle_o
);

    mag_t       mag_w [9];
    octant_t    c_oct;
    mag_t       n1;
    mag_t       n2;
    mag_t       c_mag_q;
    mag_t       n1_q;
    mag_t       n2_q;
    octant_t    oct_q;
    logic       edge_q;
    logic [5:0] flg1_q;
    logic [5:0] flg2_q;

    always_comb begin
        for (int i = 0; i < 9; i++) begin
            mag_w[i] = win_i[i][MO_W-1 -: MAG_W];
        end
    end

    assign c_oct = win_i[4][OCT_W-1:0];

    // Neighbours along the direction class
    always_comb begin
        case (c_oct[1:0])
            2'd0: begin
                n1 = mag_w[3];
                n2 = mag_w[5];
            end
            2'd1: begin
                n1 = mag_w[2];
                n2 = mag_w[6];
            end
            2'd2: begin
                n1 = mag_w[1];
                n2 = mag_w[7];
            end
            default: begin
                n1 = mag_w[0];
                n2 = mag_w[8];
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (cke_i) begin
            c_mag_q <= mag_w[4];
            n1_q    <= n1;
            n2_q    <= n2;
            oct_q   <= c_oct;
            edge_q  <= (c_mag_q > mag_t'(EDGE_TH)) && (c_mag_q >= n1_q) && (c_mag_q >= n2_q);
            angle_o <= {oct_q, 5'd0};
        end
    end

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            flg1_q <= '0;
            flg2_q <= '0;
        end else if (cke_i) begin
            flg1_q <= {s.line_first, s.line_last, s.pixel_first, s.pixel_last, s.de, s.valid};
            flg2_q <= flg1_q;
        end
    end

    assign {m.line_first, m.line_last, m.pixel_first, m.pixel_last, m.de, m.valid} = flg2_q;
    assign m.data = edge_q;

endmodule

/* img_sobel.sv */
`timescale 1ns/1ps

module img_sobel
    import canny_pkg::*;
(
    input  logic   aclk,
    input  logic   rst_n_i,
    input  logic   cke_i,
    input  pixel_t win_i [9],
    input  logic   border_i,
    img_bus_if.snk s,
    img_bus_if.src m
);

    grad_t                   px [9];
    grad_t                   gx_d;
    grad_t                   gy_d;
    grad_t                   gx_q;
    grad_t                   gy_q;
    logic                    border_q;
    logic signed [MAG_W-1:0] sq_x;
    logic signed [MAG_W-1:0] sq_y;
    mag_t                    mag_d;
    mag_t                    mag_q;
    octant_t                 oct_q;
    logic [5:0]              flg1_q;
    logic [5:0]              flg2_q;

    // Sector boundaries go to the lower sector, zero vector to sector 0
    function automatic octant_t calc_octant(input grad_t gx, input grad_t gy);
        logic [GRAD_W-1:0] ax;
        logic [GRAD_W-1:0] ay;
        octant_t           oct;
        ax = gx[GRAD_W-1] ? -gx : gx;
        ay = gy[GRAD_W-1] ? -gy : gy;
        if (gy == 0) begin
            oct = (gx < 0) ? 3'd3 : 3'd0;
        end else if (gx == 0) begin
            oct = (gy > 0) ? 3'd1 : 3'd5;
        end else if (gx > 0 && gy > 0) begin
            oct = (ay <= ax) ? 3'd0 : 3'd1;
        end else if (gy > 0) begin
            oct = (ay >= ax) ? 3'd2 : 3'd3;
        end else if (gx < 0) begin
            oct = (ay <= ax) ? 3'd4 : 3'd5;
        end else begin
            oct = (ay >= ax) ? 3'd6 : 3'd7;
        end
        return oct;
    endfunction

    always_comb begin
        for (int i = 0; i < 9; i++) begin
            px[i] = grad_t'(win_i[i]);
        end
    end

    // gy is taken upward so that octants turn counter-clockwise on screen
    assign gx_d = (px[2] + (px[5] <<< 1) + px[8]) - (px[0] + (px[3] <<< 1) + px[6]);
    assign gy_d = (px[0] + (px[1] <<< 1) + px[2]) - (px[6] + (px[7] <<< 1) + px[8]);

    assign sq_x  = gx_q * gx_q;
    assign sq_y  = gy_q * gy_q;
    assign mag_d = border_q ? '0 : mag_t'(sq_x + sq_y);

    always_ff @(posedge aclk) begin
        if (cke_i) begin
            gx_q     <= gx_d;
            gy_q     <= gy_d;
            border_q <= border_i;
            mag_q    <= mag_d;
            oct_q    <= calc_octant(gx_q, gy_q);
        end
    end

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            flg1_q <= '0;
            flg2_q <= '0;
        end else if (cke_i) begin
            flg1_q <= {s.line_first, s.line_last, s.pixel_first, s.pixel_last, s.de, s.valid};
            flg2_q <= flg1_q;
        end
    end

    assign {m.line_first, m.line_last, m.pixel_first, m.pixel_last, m.de, m.valid} = flg2_q;
    assign m.data = {mag_q, oct_q};

endmodule

/* img_window3x3.sv */
`timescale 1ns/1ps

module img_window3x3
    import canny_pkg::*;
#(
    parameter int DATA_W = 8
) (
    input  logic              aclk,
    input  logic              rst_n_i,
    input  logic              cke_i,
    img_bus_if.snk            s,
    img_bus_if.src            m,
    output logic [DATA_W-1:0] win_o [9],
    output logic              border_o
);

    // Flag delay reaches the centre tap, one line plus one pixel back
    localparam int DLY = IMG_X + 2;

    logic [DATA_W-1:0] lb1_q [IMG_X];
    logic [DATA_W-1:0] lb2_q [IMG_X];
    logic [DATA_W-1:0] win_q [3][3];
    logic [4:0]        flg_q [DLY];
    logic [4:0]        ctr;
    logic              valid_q;
    logic              shift;
    logic [1:0]        row_sel [3];
    logic [1:0]        col_sel [3];

    assign shift = cke_i & s.valid;

    // Row 2 is the newest line, column 2 the newest pixel
    always_ff @(posedge aclk) begin
        if (shift) begin
            lb1_q[0] <= s.data;
            lb2_q[0] <= lb1_q[IMG_X-1];
            for (int i = 1; i < IMG_X; i++) begin
                lb1_q[i] <= lb1_q[i-1];
                lb2_q[i] <= lb2_q[i-1];
            end
            for (int r = 0; r < 3; r++) begin
                win_q[r][0] <= win_q[r][1];
                win_q[r][1] <= win_q[r][2];
            end
            win_q[0][2] <= lb2_q[IMG_X-1];
            win_q[1][2] <= lb1_q[IMG_X-1];
            win_q[2][2] <= s.data;
        end
    end

    // Flags packed as {line_first, line_last, pixel_first, pixel_last, de}
    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            for (int i = 0; i < DLY; i++) begin
                flg_q[i] <= '0;
            end
        end else if (cke_i) begin
            valid_q <= s.valid;
            if (s.valid) begin
                flg_q[0] <= {s.line_first, s.line_last, s.pixel_first, s.pixel_last, s.de};
                for (int i = 1; i < DLY; i++) begin
                    flg_q[i] <= flg_q[i-1];
                end
            end
        end
    end

    assign ctr = flg_q[DLY-1];

    assign m.valid       = valid_q;
    assign m.line_first  = ctr[4];
    assign m.line_last   = ctr[3];
    assign m.pixel_first = ctr[2];
    assign m.pixel_last  = ctr[1];
    assign m.de          = ctr[0];
    assign m.data        = win_q[1][1];

    // Outside taps fall back on the centre row or column
    assign row_sel[0] = ctr[4] ? 2'd1 : 2'd0;
    assign row_sel[1] = 2'd1;
    assign row_sel[2] = ctr[3] ? 2'd1 : 2'd2;
    assign col_sel[0] = ctr[2] ? 2'd1 : 2'd0;
    assign col_sel[1] = 2'd1;
    assign col_sel[2] = ctr[1] ? 2'd1 : 2'd2;

    always_comb begin
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                win_o[r*3+c] = win_q[row_sel[r]][col_sel[c]];
            end
        end
    end

    assign border_o = |ctr[4:1];

endmodule

/* axi4s_img_adapter.sv */
`timescale 1ns/1ps

module axi4s_img_adapter
    import canny_pkg::*;
(
    input  logic   aclk,
    input  logic   rst_n_i,

    input  pixel_t s_axis_src_tdata_i,
    input  logic   s_axis_src_tuser_i,
    input  logic   s_axis_src_tlast_i,
    input  logic   s_axis_src_tvalid_i,
    output logic   s_axis_src_tready_o,

    output pixel_t m_axis_dst_tdata_o,
    output logic   m_axis_dst_tuser_o,
    output logic   m_axis_dst_tlast_o,
    output logic   m_axis_dst_tvalid_o,
    input  logic   m_axis_dst_tready_i,

    output logic   cke_o,
    img_bus_if.src img_src,
    img_bus_if.snk img_snk
);

    typedef enum logic {
        ST_FRAME,
        ST_FLUSH
    } state_t;

    state_t         state_q;
    logic [X_W-1:0] x_q;
    logic [Y_W-1:0] y_q;
    logic [X_W-1:0] cur_x;
    logic [Y_W-1:0] cur_y;
    logic           in_frame;
    logic           frame_start;
    logic           cke;
    logic           dst_valid_q;

    // Pipeline advances whenever the output register can take a beat
    assign cke         = ~dst_valid_q | m_axis_dst_tready_i;
    assign cke_o       = cke;
    assign in_frame    = (state_q == ST_FRAME);
    assign frame_start = in_frame & s_axis_src_tuser_i;

    assign s_axis_src_tready_o = cke & in_frame;

    // tuser restarts the raster position
    assign cur_x = frame_start ? '0 : x_q;
    assign cur_y = frame_start ? '0 : y_q;

    // ********************************************************************
    // Source side
    // ********************************************************************

    assign img_src.valid       = in_frame ? s_axis_src_tvalid_i : 1'b1;
    assign img_src.de          = in_frame;
    assign img_src.data        = s_axis_src_tdata_i;
    assign img_src.line_first  = in_frame & (cur_y == '0);
    assign img_src.line_last   = in_frame & (cur_y == Y_W'(IMG_Y - 1));
    assign img_src.pixel_first = in_frame & (cur_x == '0);
    assign img_src.pixel_last  = in_frame & s_axis_src_tlast_i;

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_FRAME;
            x_q     <= '0;
            y_q     <= '0;
        end else if (cke) begin
            if (in_frame) begin
                if (s_axis_src_tvalid_i) begin
                    if (s_axis_src_tlast_i) begin
                        x_q <= '0;
                        if (cur_y == Y_W'(IMG_Y - 1)) begin
                            y_q     <= '0;
                            state_q <= ST_FLUSH;
                        end else begin
                            y_q <= cur_y + 1'b1;
                        end
                    end else begin
                        x_q <= cur_x + 1'b1;
                        y_q <= cur_y;
                    end
                end
            end else begin
                // Blank lines, one slot per enabled cycle
                if (x_q == X_W'(IMG_X - 1)) begin
                    x_q <= '0;
                    if (y_q == Y_W'(FLUSH_LINES - 1)) begin
                        y_q     <= '0;
                        state_q <= ST_FRAME;
                    end else begin
                        y_q <= y_q + 1'b1;
                    end
                end else begin
                    x_q <= x_q + 1'b1;
                end
            end
        end
    end

    // ********************************************************************
    // Destination side
    // ********************************************************************

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dst_valid_q <= 1'b0;
        end else if (cke) begin
            dst_valid_q <= img_snk.valid & img_snk.de;
        end
    end

    always_ff @(posedge aclk) begin
        if (cke) begin
            m_axis_dst_tdata_o <= {8{img_snk.data}};
            m_axis_dst_tuser_o <= img_snk.line_first & img_snk.pixel_first;
            m_axis_dst_tlast_o <= img_snk.pixel_last;
        end
    end

    assign m_axis_dst_tvalid_o = dst_valid_q;

endmodule

/* img_bus_if.sv */
`timescale 1ns/1ps

interface img_bus_if #(
    parameter int DATA_W = 8
);
    logic              line_first;
    logic              line_last;
    logic              pixel_first;
    logic              pixel_last;
    logic              de;
    logic              valid;
    logic [DATA_W-1:0] data;

    modport src (
        output line_first, line_last, pixel_first, pixel_last, de, valid, data
    );

    modport snk (
        input  line_first, line_last, pixel_first, pixel_last, de, valid, data
    );

endinterface

/* canny_pkg.sv */
package canny_pkg;

    // Frame geometry
    localparam int IMG_X       = 8;
    localparam int IMG_Y       = 6;
    localparam int X_W         = 3;
    localparam int Y_W         = 3;
    localparam int FLUSH_LINES = 3;

    // Datapath widths
    localparam int PIX_W  = 8;
    localparam int GRAD_W = 11;
    localparam int MAG_W  = 22;
    localparam int OCT_W  = 3;
    localparam int MO_W   = MAG_W + OCT_W;

    // Squared magnitude threshold, 127*127
    localparam int EDGE_TH = 16129;

    typedef logic [PIX_W-1:0]         pixel_t;
    typedef logic signed [GRAD_W-1:0] grad_t;
    typedef logic [MAG_W-1:0]         mag_t;
    typedef logic [OCT_W-1:0]         octant_t;
    typedef logic [7:0]               angle_t;
    typedef logic [23:0]              rgb_t;

endpackage
